// ==== dv/mips_pipeline_tb.sv ====
/* pipeline testbench: serves a fixed program from a ROM on imem_addr/imem_data,
   runs an ISA model of the same program and checks every register write against it */
module mips_pipeline_tb;

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int PROG_LEN   = 30;
    localparam int TIMEOUT    = 500;           // cycles allowed between two writes

    logic        SYS_clk;
    logic        SYS_reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] rom [64];
    logic [31:0] mreg [32];                    // model register file
    logic [31:0] mdmem [DMEM_WORDS];           // model data memory
    logic [4:0]  exp_addr [64];
    logic [31:0] exp_data [64];
    logic [4:0]  exp_addr_now;
    logic [31:0] exp_data_now;
    int          n_exp = 0;
    int          wr_idx = 0;
    logic [31:0] rng = 32'h4fbd_b426;

    tb_clock #(.PERIOD(4)) u_clock (.clk(SYS_clk));

    mips_pipeline #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // small signed values keep sums and addresses easy to follow
    function automatic logic [15:0] rand_imm();
        rng = lcg(rng);
        return {{4{rng[27]}}, rng[27:16]};
    endfunction

    function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {mips_pkg::OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < 30'(PROG_LEN))
            return rom[addr[7:2]];
        else
            return '0;                         // nop past the program
    endfunction

    task automatic load_program();
        logic [4:0]  base;
        logic [15:0] off;
        rng  = lcg(rng);
        base = {3'b000, rng[25:24]} + 5'd1;    // r1 to r4
        off  = rand_imm();
        rom[0]  = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd1, rand_imm());
        rom[1]  = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd2, rand_imm());
        rom[2]  = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd3, rand_imm() | 16'h0001);
        rom[3]  = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd4, rand_imm());
        rom[4]  = r_word(5'd1, 5'd2, 5'd5, mips_pkg::FN_ADD);
        rom[5]  = r_word(5'd3, 5'd4, 5'd6, mips_pkg::FN_SUB);
        rom[6]  = r_word(5'd1, 5'd3, 5'd7, mips_pkg::FN_AND);
        rom[7]  = r_word(5'd2, 5'd4, 5'd8, mips_pkg::FN_OR);
        rom[8]  = r_word(5'd1, 5'd2, 5'd9, mips_pkg::FN_SLT);
        rom[9]  = i_word(mips_pkg::OPC_ADDI, 5'd5, 5'd10, rand_imm());
        rom[10] = r_word(5'd10, 5'd6, 5'd11, mips_pkg::FN_ADD);    // distance 1
        rom[11] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd12, rand_imm());
        rom[12] = r_word(5'd11, 5'd12, 5'd13, mips_pkg::FN_SUB);   // distances 2 and 1
        rom[13] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd14, rand_imm());
        rom[14] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd15, rand_imm());
        rom[15] = r_word(5'd13, 5'd9, 5'd16, mips_pkg::FN_SLT);    // distance 3
        rom[16] = i_word(mips_pkg::OPC_SW, base, 5'd13, off);
        rom[17] = i_word(mips_pkg::OPC_LW, base, 5'd17, off);      // same address
        rom[18] = r_word(5'd17, 5'd16, 5'd18, mips_pkg::FN_ADD);   // load used at once
        rom[19] = i_word(mips_pkg::OPC_BEQ, 5'd3, 5'd3, 16'd2);    // taken
        rom[20] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd19, rand_imm());
        rom[21] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd20, rand_imm()); // skipped
        rom[22] = i_word(mips_pkg::OPC_BEQ, 5'd0, 5'd3, 16'd2);    // not taken, r3 nonzero
        rom[23] = i_word(mips_pkg::OPC_ADDI, 5'd19, 5'd21, rand_imm());
        rom[24] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd22, rand_imm() | 16'h0001);
        rom[25] = i_word(mips_pkg::OPC_BNE, 5'd22, 5'd0, 16'd2);   // taken, waits on r22
        rom[26] = r_word(5'd21, 5'd22, 5'd23, mips_pkg::FN_ADD);   // delay slot
        rom[27] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd24, rand_imm()); // skipped
        rom[28] = i_word(mips_pkg::OPC_ADDI, 5'd0, 5'd0, rand_imm());  // r0, no write
        rom[29] = r_word(5'd23, 5'd18, 5'd25, mips_pkg::FN_OR);
    endtask

    task automatic record_write(input logic [4:0] dest, input logic [31:0] val);
        if (dest != 5'd0)
        begin
            mreg[dest]           = val;
            exp_addr[n_exp[5:0]] = dest;
            exp_data[n_exp[5:0]] = val;
            n_exp                = n_exp + 1;
        end
    endtask

    // one instruction per step, a branch redirects after its delay slot
    task automatic run_model();
        logic [31:0]        pc;
        logic [31:0]        npc;
        logic [31:0]        after;
        logic [31:0]        w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        imm;
        logic [31:0]        ea;
        logic [31:0]        res;
        logic [DMEM_AW-1:0] widx;
        int                 steps;
        pc    = '0;
        npc   = 32'd4;
        steps = 0;
        mreg  = '{default: '0};
        while (pc[31:2] < 30'(PROG_LEN) && steps < 200)
        begin
            w     = rom[pc[7:2]];
            a     = mreg[w[25:21]];
            b     = mreg[w[20:16]];
            imm   = {{16{w[15]}}, w[15:0]};
            ea    = a + imm;
            widx  = DMEM_AW'((ea >> 2) % DMEM_WORDS);
            after = npc + 32'd4;
            case (w[31:26])
                mips_pkg::OPC_RTYPE:
                begin
                    case (w[5:0])
                        mips_pkg::FN_SUB: res = a - b;
                        mips_pkg::FN_AND: res = a & b;
                        mips_pkg::FN_OR:  res = a | b;
                        mips_pkg::FN_SLT: res = {31'b0, $signed(a) < $signed(b)};
                        default:          res = a + b;
                    endcase
                    record_write(w[15:11], res);
                end
                mips_pkg::OPC_ADDI: record_write(w[20:16], ea);
                mips_pkg::OPC_LW:   record_write(w[20:16], mdmem[widx]);
                mips_pkg::OPC_SW:   mdmem[widx] = b;
                mips_pkg::OPC_BEQ:  if (a == b) after = pc + 32'd4 + {imm[29:0], 2'b00};
                mips_pkg::OPC_BNE:  if (a != b) after = pc + 32'd4 + {imm[29:0], 2'b00};
                default: ;
            endcase
            pc    = npc;
            npc   = after;
            steps = steps + 1;
        end
    endtask

    assign exp_addr_now = exp_addr[wr_idx[5:0]];
    assign exp_data_now = exp_data[wr_idx[5:0]];

    always @(posedge SYS_clk)
    begin
        #1;
        imem_data = fetch_word(imem_addr);     // rom read a little after the edge
    end

    always @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wr_idx <= 0;
        else if (wb_en)
            wr_idx <= wr_idx + 1;
    end

    a_reset_state: assert property (@(posedge SYS_clk)
        SYS_reset |=> !wb_en && (imem_addr == '0))
    else
    begin
        $display("ERR wb_en got %h exp 0, imem_addr got %h exp 0",
                 $sampled(wb_en), $sampled(imem_addr));
        $display("TEST FAILED");
        $fatal(1);
    end

    a_write_match: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_en && (wr_idx < n_exp) |-> (wb_addr == exp_addr_now) && (wb_data == exp_data_now))
    else
    begin
        $display("ERR wb_addr got %h exp %h, wb_data got %h exp %h",
                 $sampled(wb_addr), $sampled(exp_addr_now),
                 $sampled(wb_data), $sampled(exp_data_now));
        $display("TEST FAILED");
        $fatal(1);
    end

    a_no_extra_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_en |-> wr_idx < n_exp)
    else
    begin
        $display("register write seen after the last expected write");
        $display("TEST FAILED");
        $fatal(1);
    end

    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_en |-> wb_addr != '0)
    else
    begin
        $display("register write enabled with r0 as destination");
        $display("TEST FAILED");
        $fatal(1);
    end

    initial
    begin : main
        int idle;
        SYS_reset = 1'b1;
        imem_data = '0;
        idle      = 0;
        load_program();
        run_model();
        repeat (2) @(posedge SYS_clk);
        #1 SYS_reset = 1'b0;
        while (wr_idx < n_exp && idle < TIMEOUT)
        begin
            @(negedge SYS_clk);
            idle = wb_en ? 0 : idle + 1;
        end
        if (wr_idx < n_exp)
        begin
            $display("register writes stopped before the program ended");
            $display("TEST FAILED");
            $fatal(1);
        end
        else
        begin
            repeat (20) @(negedge SYS_clk);    // window for stray writes
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== dv/tb_clock.sv ====
/* free-running testbench clock, starts low */
module tb_clock
#(
    parameter int PERIOD = 4
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// ==== mips_pipeline.f ====
rtl/mips_pkg.sv
rtl/stage_if.sv
rtl/fetch_decode.sv
rtl/hazard_stall.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/mips_pipeline.sv
dv/tb_clock.sv
dv/mips_pipeline_tb.sv

// ==== rtl/execute_stage.sv ====
/* execute register, ALU control and ALU
   a stall from decode pushes a nop bubble into this stage */
module execute_stage
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  logic                        stall,
    id_ex_if.dst                        ide,
    ex_mem_if.src                       exm,
    output logic [mips_pkg::REG_AW-1:0] ex_dest,
    output logic                        ex_regwr
);

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_SLT = 3'd4;

    mips_pkg::instr_u            ex_instr;
    logic [mips_pkg::CTRL_W-1:0] ex_ctrl;
    logic [mips_pkg::WORD_W-1:0] ex_rs_val;
    logic [mips_pkg::WORD_W-1:0] ex_rt_val;
    logic [mips_pkg::WORD_W-1:0] ex_imm;
    logic [mips_pkg::WORD_W-1:0] alu_b;
    logic [1:0]                  alu_op;
    logic [2:0]                  alu_sel;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_instr <= '0;                     // bubble
            ex_ctrl  <= '0;
            ex_dest  <= '0;
        end
        else
        begin
            ex_instr <= ide.instr;
            ex_ctrl  <= ide.ctrl;
            ex_dest  <= ide.dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_rs_val <= ide.rs_val;
        ex_rt_val <= ide.rt_val;
        ex_imm    <= ide.imm;
    end

    assign alu_op = {ex_ctrl[mips_pkg::C_ALUOP1], ex_ctrl[mips_pkg::C_ALUOP0]};

    always_comb
    begin
        case (alu_op)
            2'b00:   alu_sel = ALU_ADD;         // lw, sw, addi
            2'b01:   alu_sel = ALU_SUB;         // beq, bne
            default:
            begin
                case (ex_instr.r.funct)
                    mips_pkg::FN_SUB: alu_sel = ALU_SUB;
                    mips_pkg::FN_AND: alu_sel = ALU_AND;
                    mips_pkg::FN_OR:  alu_sel = ALU_OR;
                    mips_pkg::FN_SLT: alu_sel = ALU_SLT;
                    default:          alu_sel = ALU_ADD;
                endcase
            end
        endcase
    end

    assign alu_b = ex_ctrl[mips_pkg::C_ALUSRC] ? ex_imm : ex_rt_val;

    always_comb
    begin
        case (alu_sel)
            ALU_SUB: exm.alu_result = ex_rs_val - alu_b;
            ALU_AND: exm.alu_result = ex_rs_val & alu_b;
            ALU_OR:  exm.alu_result = ex_rs_val | alu_b;
            ALU_SLT: exm.alu_result = {{(mips_pkg::WORD_W-1){1'b0}},
                                       ($signed(ex_rs_val) < $signed(alu_b))};
            default: exm.alu_result = ex_rs_val + alu_b;
        endcase
    end

    assign exm.ctrl       = ex_ctrl;
    assign exm.store_data = ex_rt_val;
    assign exm.dest       = ex_dest;
    assign ex_regwr       = ex_ctrl[mips_pkg::C_REGWR];

endmodule

// ==== rtl/fetch_decode.sv ====
/* fetch and decode: program counter, decode register, control decoder,
   register file and the early branch compare with one delay slot */
module fetch_decode
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  logic [mips_pkg::WORD_W-1:0] imem_data,
    input  logic                        stall,
    input  logic                        wb_en,
    input  logic [mips_pkg::REG_AW-1:0] wb_addr,
    input  logic [mips_pkg::WORD_W-1:0] wb_data,
    output logic [mips_pkg::WORD_W-1:0] pc,
    output mips_pkg::instr_u            d_instr,
    id_ex_if.src                        ide
);

    logic [mips_pkg::WORD_W-1:0] d_pc;
    logic [mips_pkg::CTRL_W-1:0] ctrl;
    logic [mips_pkg::WORD_W-1:0] regs [2**mips_pkg::REG_AW];
    logic [mips_pkg::WORD_W-1:0] rs_val;
    logic [mips_pkg::WORD_W-1:0] rt_val;
    logic [mips_pkg::WORD_W-1:0] imm_ext;
    logic [mips_pkg::WORD_W-1:0] br_target;
    logic                        br_taken;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc      <= '0;
            d_instr <= '0;                              // nop in decode
            d_pc    <= '0;
        end
        else if (!stall)
        begin
            pc      <= br_taken ? br_target : pc + mips_pkg::WORD_W'(4);
            d_instr <= imem_data;                       // delay slot on a taken branch
            d_pc    <= pc;
        end
    end

    always_comb
    begin
        ctrl = '0;
        case (d_instr.r.opcode)
            mips_pkg::OPC_RTYPE:
            begin
                ctrl[mips_pkg::C_REGDST] = 1'b1;
                ctrl[mips_pkg::C_ALUOP1] = 1'b1;        // alu follows funct
                ctrl[mips_pkg::C_REGWR]  = 1'b1;
            end
            mips_pkg::OPC_ADDI:
            begin
                ctrl[mips_pkg::C_ALUSRC] = 1'b1;
                ctrl[mips_pkg::C_REGWR]  = 1'b1;
            end
            mips_pkg::OPC_LW:
            begin
                ctrl[mips_pkg::C_ALUSRC]  = 1'b1;
                ctrl[mips_pkg::C_MEMRD]   = 1'b1;
                ctrl[mips_pkg::C_MEM2REG] = 1'b1;
                ctrl[mips_pkg::C_REGWR]   = 1'b1;
            end
            mips_pkg::OPC_SW:
            begin
                ctrl[mips_pkg::C_ALUSRC] = 1'b1;
                ctrl[mips_pkg::C_MEMWR]  = 1'b1;
            end
            mips_pkg::OPC_BEQ, mips_pkg::OPC_BNE:
                ctrl[mips_pkg::C_ALUOP0] = 1'b1;        // subtract, result unused
            default:
                ctrl = '0;                              // unknown opcode runs as nop
        endcase
    end

    // architectural registers start at zero, r0 is never written
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int k = 0; k < 2**mips_pkg::REG_AW; k++)
                regs[k] <= '0;
        end
        else if (wb_en)
            regs[wb_addr] <= wb_data;
    end

    assign rs_val  = (d_instr.r.rs == '0) ? '0 : regs[d_instr.r.rs];
    assign rt_val  = (d_instr.i.rt == '0) ? '0 : regs[d_instr.i.rt];
    assign imm_ext = {{16{d_instr.i.imm16[15]}}, d_instr.i.imm16};

    assign br_target = d_pc + mips_pkg::WORD_W'(4)
                       + {imm_ext[mips_pkg::WORD_W-3:0], 2'b00};
    assign br_taken  = ((d_instr.i.opcode == mips_pkg::OPC_BEQ) && (rs_val == rt_val))
                    || ((d_instr.i.opcode == mips_pkg::OPC_BNE) && (rs_val != rt_val));

    assign ide.instr  = d_instr;
    assign ide.ctrl   = ctrl;
    assign ide.rs_val = rs_val;
    assign ide.rt_val = rt_val;
    assign ide.imm    = imm_ext;
    assign ide.dest   = ctrl[mips_pkg::C_REGDST] ? d_instr.r.rd : d_instr.i.rt;

    // register file write port never targets r0
    a_no_r0_write: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_en |-> (wb_addr != '0));

endmodule

// ==== rtl/hazard_stall.sv ====
/* read-after-write check of the decode sources against EX, MEM and WB,
   and the stall counter that freezes fetch and decode until the value is written */
module hazard_stall
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  mips_pkg::instr_u            d_instr,
    input  logic [mips_pkg::REG_AW-1:0] ex_dest,
    input  logic                        ex_regwr,
    input  logic [mips_pkg::REG_AW-1:0] mem_dest,
    input  logic                        mem_regwr,
    input  logic [mips_pkg::REG_AW-1:0] wb_dest,
    input  logic                        wb_regwr,
    output logic                        stall
);

    logic [1:0] cnt;
    logic [1:0] load_val;
    logic       reads_rt;
    logic       hit_ex;
    logic       hit_mem;
    logic       hit_wb;

    function automatic logic src_hit(input logic [mips_pkg::REG_AW-1:0] src,
                                     input logic [mips_pkg::REG_AW-1:0] dest,
                                     input logic                        regwr);
        return regwr && (src != '0) && (src == dest);
    endfunction

    assign reads_rt = (d_instr.i.opcode == mips_pkg::OPC_RTYPE)
                   || (d_instr.i.opcode == mips_pkg::OPC_BEQ)
                   || (d_instr.i.opcode == mips_pkg::OPC_BNE)
                   || (d_instr.i.opcode == mips_pkg::OPC_SW);

    assign hit_ex  = src_hit(d_instr.r.rs, ex_dest, ex_regwr)
                  || (reads_rt && src_hit(d_instr.r.rt, ex_dest, ex_regwr));
    assign hit_mem = src_hit(d_instr.r.rs, mem_dest, mem_regwr)
                  || (reads_rt && src_hit(d_instr.r.rt, mem_dest, mem_regwr));
    assign hit_wb  = src_hit(d_instr.r.rs, wb_dest, wb_regwr)
                  || (reads_rt && src_hit(d_instr.r.rt, wb_dest, wb_regwr));

    // nearest producer sets the longest wait
    assign load_val = hit_ex ? 2'd3 : hit_mem ? 2'd2 : hit_wb ? 2'd1 : 2'd0;
    assign stall    = (cnt != 2'd0) || (load_val != 2'd0);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            cnt <= 2'd0;
        else if (cnt != 2'd0)
            cnt <= cnt - 2'd1;
        else
            cnt <= load_val;
    end

    // last stall cycle finds no producer still in flight
    a_wait_covers_producer: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (cnt == 2'd1) |-> !(hit_ex || hit_mem || hit_wb));

endmodule

// ==== rtl/memory_stage.sv ====
/* memory register and word-addressed data memory
   stores write at the end of the cycle, loads read combinationally */
module memory_stage
#(
    parameter int DMEM_WORDS = 64
)
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    ex_mem_if.dst                       exm,
    output logic [mips_pkg::CTRL_W-1:0] mem_ctrl,
    output logic [mips_pkg::WORD_W-1:0] mem_alu_result,
    output logic [mips_pkg::WORD_W-1:0] mem_load_data,
    output logic [mips_pkg::REG_AW-1:0] mem_dest
);

    localparam int DMEM_AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    logic [mips_pkg::WORD_W-1:0] store_q;
    logic [mips_pkg::WORD_W-1:0] dmem [DMEM_WORDS];
    logic [mips_pkg::WORD_W-1:0] word_addr;
    logic [DMEM_AW-1:0]          dmem_idx;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_ctrl <= '0;
            mem_dest <= '0;
        end
        else
        begin
            mem_ctrl <= exm.ctrl;
            mem_dest <= exm.dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= exm.alu_result;
        store_q        <= exm.store_data;
    end

    assign word_addr = mem_alu_result >> 2;                 // byte to word address
    assign dmem_idx  = DMEM_AW'(word_addr % DMEM_WORDS);    // wraps over the depth

    always_ff @(posedge SYS_clk)
    begin
        if (mem_ctrl[mips_pkg::C_MEMWR])
            dmem[dmem_idx] <= store_q;
    end

    assign mem_load_data = mem_ctrl[mips_pkg::C_MEMRD] ? dmem[dmem_idx] : '0;

    // decoder never issues a load and a store in one word
    a_rd_wr_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_ctrl[mips_pkg::C_MEMRD] && mem_ctrl[mips_pkg::C_MEMWR]));

endmodule

// ==== rtl/mips_pipeline.sv ====
/* top of the five-stage pipeline, instruction memory sits outside on imem_addr/imem_data
   and the register writes are visible on the wb_* ports */
module mips_pipeline
#(
    parameter int DMEM_WORDS = 64
)
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    output logic [mips_pkg::WORD_W-1:0] imem_addr,
    input  logic [mips_pkg::WORD_W-1:0] imem_data,
    output logic                        wb_en,
    output logic [mips_pkg::REG_AW-1:0] wb_addr,
    output logic [mips_pkg::WORD_W-1:0] wb_data
);

    mips_pkg::instr_u            d_instr;
    logic                        stall;
    logic [mips_pkg::REG_AW-1:0] ex_dest;
    logic                        ex_regwr;
    logic [mips_pkg::CTRL_W-1:0] mem_ctrl;
    logic [mips_pkg::WORD_W-1:0] mem_alu_result;
    logic [mips_pkg::WORD_W-1:0] mem_load_data;
    logic [mips_pkg::REG_AW-1:0] mem_dest;

    id_ex_if  ide_bus ();
    ex_mem_if exm_bus ();

    fetch_decode u_fetch_decode (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_data (imem_data),
        .stall     (stall),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .pc        (imem_addr),         // pc goes straight to fetch
        .d_instr   (d_instr),
        .ide       (ide_bus.src)
    );

    hazard_stall u_hazard_stall (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .d_instr   (d_instr),
        .ex_dest   (ex_dest),
        .ex_regwr  (ex_regwr),
        .mem_dest  (mem_dest),
        .mem_regwr (mem_ctrl[mips_pkg::C_REGWR]),
        .wb_dest   (wb_addr),
        .wb_regwr  (wb_en),
        .stall     (stall)
    );

    execute_stage u_execute_stage (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .stall     (stall),
        .ide       (ide_bus.dst),
        .exm       (exm_bus.src),
        .ex_dest   (ex_dest),
        .ex_regwr  (ex_regwr)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory_stage (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .exm            (exm_bus.dst),
        .mem_ctrl       (mem_ctrl),
        .mem_alu_result (mem_alu_result),
        .mem_load_data  (mem_load_data),
        .mem_dest       (mem_dest)
    );

    writeback_stage u_writeback_stage (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .mem_ctrl       (mem_ctrl),
        .mem_alu_result (mem_alu_result),
        .mem_load_data  (mem_load_data),
        .mem_dest       (mem_dest),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

endmodule

// ==== rtl/mips_pkg.sv ====
/* opcodes, funct codes, control-bit layout and the two views of an instruction word,
   shared by every stage of the pipeline through scoped names */
package mips_pkg;

    localparam int WORD_W = 32;                 // data and instruction width
    localparam int REG_AW = 5;                  // register address width
    localparam int CTRL_W = 8;                  // control vector width

    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDI  = 6'h08;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam int C_REGDST  = 0;               // write rd, not rt
    localparam int C_ALUSRC  = 1;               // b operand is the immediate
    localparam int C_ALUOP0  = 2;
    localparam int C_ALUOP1  = 3;
    localparam int C_MEMRD   = 4;
    localparam int C_MEMWR   = 5;
    localparam int C_MEM2REG = 6;               // load data to register
    localparam int C_REGWR   = 7;

    // one word, decoded as register or immediate format
    typedef union packed
    {
        struct packed
        {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [REG_AW-1:0] rd;
            logic [4:0]        shamt;
            logic [5:0]        funct;
        } r;
        struct packed
        {
            logic [5:0]        opcode;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [15:0]       imm16;
        } i;
    } instr_u;

endpackage

// ==== rtl/stage_if.sv ====
/* pipeline register bundles between decode and execute, and between execute and memory
   the producing stage takes src, the registering stage takes dst */
interface id_ex_if;

    mips_pkg::instr_u                instr;
    logic [mips_pkg::CTRL_W-1:0]     ctrl;
    logic [mips_pkg::WORD_W-1:0]     rs_val;
    logic [mips_pkg::WORD_W-1:0]     rt_val;
    logic [mips_pkg::WORD_W-1:0]     imm;       // sign extended
    logic [mips_pkg::REG_AW-1:0]     dest;      // rd or rt

    modport src (output instr, ctrl, rs_val, rt_val, imm, dest);
    modport dst (input instr, ctrl, rs_val, rt_val, imm, dest);

endinterface

interface ex_mem_if;

    logic [mips_pkg::CTRL_W-1:0]     ctrl;
    logic [mips_pkg::WORD_W-1:0]     alu_result;
    logic [mips_pkg::WORD_W-1:0]     store_data; // rt value for sw
    logic [mips_pkg::REG_AW-1:0]     dest;

    modport src (output ctrl, alu_result, store_data, dest);
    modport dst (input ctrl, alu_result, store_data, dest);

endinterface

// ==== rtl/writeback_stage.sv ====
/* write-back register and result select
   drives the register file write port for one cycle per instruction */
module writeback_stage
(
    input  logic                        SYS_clk,
    input  logic                        SYS_reset,
    input  logic [mips_pkg::CTRL_W-1:0] mem_ctrl,
    input  logic [mips_pkg::WORD_W-1:0] mem_alu_result,
    input  logic [mips_pkg::WORD_W-1:0] mem_load_data,
    input  logic [mips_pkg::REG_AW-1:0] mem_dest,
    output logic                        wb_en,
    output logic [mips_pkg::REG_AW-1:0] wb_addr,
    output logic [mips_pkg::WORD_W-1:0] wb_data
);

    logic [mips_pkg::CTRL_W-1:0] wb_ctrl;
    logic [mips_pkg::WORD_W-1:0] wb_alu_result;
    logic [mips_pkg::WORD_W-1:0] wb_load_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_ctrl <= '0;
            wb_addr <= '0;
        end
        else
        begin
            wb_ctrl <= mem_ctrl;
            wb_addr <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= mem_load_data;
    end

    assign wb_en   = wb_ctrl[mips_pkg::C_REGWR] && (wb_addr != '0);   // r0 writes dropped
    assign wb_data = wb_ctrl[mips_pkg::C_MEM2REG] ? wb_load_data : wb_alu_result;

    // load data is selected only for a register-writing load
    a_mem2reg_writes: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        wb_ctrl[mips_pkg::C_MEM2REG] |-> wb_ctrl[mips_pkg::C_REGWR]);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the pipeline testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_pipeline_tb -f mips_pipeline.f

out=$(./obj_dir/Vmips_pipeline_tb) || true
echo "$out"
echo "$out" | grep -qx "TEST OK"
